// File: src/axi_sram_cfg.svh
// AXI SRAM slave configuration: bus widths and SRAM depth
`ifndef AXI_SRAM_CFG_SVH
`define AXI_SRAM_CFG_SVH
`default_nettype none

// Bus widths
`define AXI_SRAM_DATA_W 64
`define AXI_SRAM_ADDR_W 32
`define AXI_SRAM_ID_W   4

// Number of data words in the SRAM
`define AXI_SRAM_DEPTH  256

// Derived widths
`define AXI_SRAM_STRB_W (`AXI_SRAM_DATA_W / 8)
`define AXI_SRAM_OFS_W  ($clog2(`AXI_SRAM_STRB_W))
`define AXI_SRAM_IDX_W  ($clog2(`AXI_SRAM_DEPTH))

`default_nettype wire
`endif

// File: src/axi_sram_pkg.sv
// AXI SRAM slave types: channel beats, response codes and FSM states
`include "axi_sram_cfg.svh"
`default_nettype none

package axi_sram_pkg;

  // ----------------------------------------
  // Response codes and FSM states
  // ----------------------------------------
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_DATA = 2'd1,
    WR_RESP = 2'd2
  } wr_state_e;

  typedef enum logic [0:0] {
    RD_IDLE = 1'b0,
    RD_RESP = 1'b1
  } rd_state_e;

  // ----------------------------------------
  // AXI channel beats
  // ----------------------------------------
  typedef struct packed {
    logic [`AXI_SRAM_ID_W-1:0]   id;
    logic [`AXI_SRAM_ADDR_W-1:0] addr;
    logic [7:0]                  len;
    logic [1:0]                  size;
  } axi_aw_t;

  // Read address carries the same fields
  typedef axi_aw_t axi_ar_t;

  typedef struct packed {
    logic [`AXI_SRAM_DATA_W-1:0] data;
    logic [`AXI_SRAM_STRB_W-1:0] strb;
    logic                        last;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_SRAM_ID_W-1:0] id;
    axi_resp_e                 resp;
  } axi_b_t;

  typedef struct packed {
    logic [`AXI_SRAM_ID_W-1:0]   id;
    logic [`AXI_SRAM_DATA_W-1:0] data;
    axi_resp_e                   resp;
    logic                        last;
  } axi_r_t;

  // SRAM write command
  typedef struct packed {
    logic [`AXI_SRAM_IDX_W-1:0]  idx;
    logic [`AXI_SRAM_DATA_W-1:0] data;
    logic [`AXI_SRAM_STRB_W-1:0] strb;
  } sram_wr_t;

endpackage

`default_nettype wire

// File: src/axi_sram_wr_req.sv
// Write-request stage that pairs AW with W, checks the request and issues the SRAM write
`include "axi_sram_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module axi_sram_wr_req (
  input  wire                     i_aclk,
  input  wire                     i_rst_n,
  input  axi_sram_pkg::axi_aw_t   i_aw,
  input  wire                     i_awvalid,
  output logic                    o_awready,
  input  axi_sram_pkg::axi_w_t    i_w,
  input  wire                     i_wvalid,
  output logic                    o_wready,
  output axi_sram_pkg::sram_wr_t  o_sram_wr,
  output logic                    o_sram_we,
  output axi_sram_pkg::axi_b_t    o_b,
  output logic                    o_b_load,
  input  wire                     i_b_done
);

  axi_sram_pkg::wr_state_e state_q;
  axi_sram_pkg::wr_state_e state_d;
  axi_sram_pkg::axi_aw_t   aw_q;
  logic                    aw_fire;
  logic                    w_fire;
  logic                    wr_ok;

  assign o_awready = (state_q == axi_sram_pkg::WR_IDLE);
  assign o_wready  = (state_q == axi_sram_pkg::WR_DATA);
  assign aw_fire   = i_awvalid & o_awready;
  assign w_fire    = i_wvalid & o_wready;

  // Single beat, inside the SRAM, and W marked last
  assign wr_ok = (aw_q.len == 8'd0) && i_w.last &&
                 ~|aw_q.addr[`AXI_SRAM_ADDR_W-1:`AXI_SRAM_OFS_W+`AXI_SRAM_IDX_W];

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      axi_sram_pkg::WR_IDLE: if (aw_fire) state_d = axi_sram_pkg::WR_DATA;
      axi_sram_pkg::WR_DATA: if (w_fire) state_d = axi_sram_pkg::WR_RESP;
      axi_sram_pkg::WR_RESP: if (i_b_done) state_d = axi_sram_pkg::WR_IDLE;
      default:               state_d = axi_sram_pkg::WR_IDLE;
    endcase
  end

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= axi_sram_pkg::WR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address beat held until the data beat arrives
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      aw_q <= i_aw;
    end
  end

  assign o_sram_wr = '{idx:  aw_q.addr[`AXI_SRAM_OFS_W +: `AXI_SRAM_IDX_W],
                       data: i_w.data,
                       strb: i_w.strb};
  assign o_sram_we = w_fire & wr_ok;

  assign o_b      = '{id:   aw_q.id,
                      resp: wr_ok ? axi_sram_pkg::OKAY : axi_sram_pkg::SLVERR};
  assign o_b_load = w_fire;

  // B handshake only while a write waits for its response
  a_b_done_in_resp: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_b_done |-> (state_q == axi_sram_pkg::WR_RESP));

endmodule

`default_nettype wire

// File: src/axi_sram_rd_req.sv
// Read-request stage: accepts AR, checks the request, issues the SRAM read
`include "axi_sram_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module axi_sram_rd_req (
  input  wire                          i_aclk,
  input  wire                          i_rst_n,
  input  axi_sram_pkg::axi_ar_t        i_ar,
  input  wire                          i_arvalid,
  output logic                         o_arready,
  output logic                         o_rd_en,
  output logic [`AXI_SRAM_IDX_W-1:0]   o_rd_idx,
  output logic [`AXI_SRAM_ID_W-1:0]    o_r_id,
  output axi_sram_pkg::axi_resp_e      o_r_resp,
  output logic                         o_r_load,
  input  wire                          i_r_done
);

  axi_sram_pkg::rd_state_e state_q;
  logic                    ar_fire;
  logic                    rd_ok;

  assign o_arready = (state_q == axi_sram_pkg::RD_IDLE);
  assign ar_fire   = i_arvalid & o_arready;

  assign rd_ok = (i_ar.len == 8'd0) &&
                 ~|i_ar.addr[`AXI_SRAM_ADDR_W-1:`AXI_SRAM_OFS_W+`AXI_SRAM_IDX_W];

  // Idle until R is taken by the master
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= axi_sram_pkg::RD_IDLE;
    end else if (ar_fire) begin
      state_q <= axi_sram_pkg::RD_RESP;
    end else if (i_r_done) begin
      state_q <= axi_sram_pkg::RD_IDLE;
    end
  end

  assign o_rd_en  = ar_fire & rd_ok;
  assign o_rd_idx = i_ar.addr[`AXI_SRAM_OFS_W +: `AXI_SRAM_IDX_W];
  assign o_r_id   = i_ar.id;
  assign o_r_resp = rd_ok ? axi_sram_pkg::OKAY : axi_sram_pkg::SLVERR;
  assign o_r_load = ar_fire;

endmodule

`default_nettype wire

// File: src/axi_sram_array.sv
// Byte-strobed SRAM with one write port and one registered read port
`include "axi_sram_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module axi_sram_array (
  input  wire                          i_aclk,
  input  axi_sram_pkg::sram_wr_t       i_sram_wr,
  input  wire                          i_we,
  input  wire                          i_rd_en,
  input  wire [`AXI_SRAM_IDX_W-1:0]    i_rd_idx,
  output logic [`AXI_SRAM_DATA_W-1:0]  o_rd_data
);

  logic [`AXI_SRAM_DATA_W-1:0] mem [`AXI_SRAM_DEPTH];

  // Cleared at power-up
  initial begin
    for (int i = 0; i < `AXI_SRAM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // Masked write, one lane per strobe bit
  always_ff @(posedge i_aclk) begin
    if (i_we) begin
      for (int b = 0; b < `AXI_SRAM_STRB_W; b++) begin
        if (i_sram_wr.strb[b]) begin
          mem[i_sram_wr.idx][b*8 +: 8] <= i_sram_wr.data[b*8 +: 8];
        end
      end
    end
  end

  // Old data returned on a same-edge write
  always_ff @(posedge i_aclk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_idx];
    end
  end

endmodule

`default_nettype wire

// File: src/axi_sram_resp.sv
// Response stage: holds the B and R beats until the master accepts them
`include "axi_sram_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module axi_sram_resp (
  input  wire                          i_aclk,
  input  wire                          i_rst_n,
  input  axi_sram_pkg::axi_b_t         i_b,
  input  wire                          i_b_load,
  output axi_sram_pkg::axi_b_t         o_b,
  output logic                         o_bvalid,
  input  wire                          i_bready,
  output logic                         o_b_done,
  input  wire [`AXI_SRAM_ID_W-1:0]     i_r_id,
  input  axi_sram_pkg::axi_resp_e      i_r_resp,
  input  wire                          i_r_load,
  input  wire [`AXI_SRAM_DATA_W-1:0]   i_rd_data,
  output axi_sram_pkg::axi_r_t         o_r,
  output logic                         o_rvalid,
  input  wire                          i_rready,
  output logic                         o_r_done
);

  logic [`AXI_SRAM_ID_W-1:0] r_id_q;
  axi_sram_pkg::axi_resp_e   r_resp_q;

  assign o_b_done = o_bvalid & i_bready;
  assign o_r_done = o_rvalid & i_rready;

  // ----------------------------------------
  // Valid flags
  // ----------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_bvalid <= 1'b0;
      o_rvalid <= 1'b0;
    end else begin
      if (i_b_load) begin
        o_bvalid <= 1'b1;
      end else if (o_b_done) begin
        o_bvalid <= 1'b0;
      end
      if (i_r_load) begin
        o_rvalid <= 1'b1;
      end else if (o_r_done) begin
        o_rvalid <= 1'b0;
      end
    end
  end

  // Beat payloads
  always_ff @(posedge i_aclk) begin
    if (i_b_load) begin
      o_b <= i_b;
    end
    if (i_r_load) begin
      r_id_q   <= i_r_id;
      r_resp_q <= i_r_resp;
    end
  end

  // SRAM data lands one cycle after the load, zeroed on error
  assign o_r = '{id:   r_id_q,
                 data: (r_resp_q == axi_sram_pkg::OKAY) ? i_rd_data : '0,
                 resp: r_resp_q,
                 last: 1'b1};

  // ----------------------------------------
  // Beats hold while stalled
  // ----------------------------------------
  a_b_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_b));

  a_r_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_r));

endmodule

`default_nettype wire

// File: src/axi_sram_top.sv
// AXI4 single-beat memory slave in front of an on-chip SRAM
`include "axi_sram_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module axi_sram_top (
  input  wire                    i_aclk,
  input  wire                    i_rst_n,
  input  axi_sram_pkg::axi_aw_t  i_aw,
  input  wire                    i_awvalid,
  output logic                   o_awready,
  input  axi_sram_pkg::axi_w_t   i_w,
  input  wire                    i_wvalid,
  output logic                   o_wready,
  output axi_sram_pkg::axi_b_t   o_b,
  output logic                   o_bvalid,
  input  wire                    i_bready,
  input  axi_sram_pkg::axi_ar_t  i_ar,
  input  wire                    i_arvalid,
  output logic                   o_arready,
  output axi_sram_pkg::axi_r_t   o_r,
  output logic                   o_rvalid,
  input  wire                    i_rready
);

  axi_sram_pkg::sram_wr_t      sram_wr;
  logic                        sram_we;
  axi_sram_pkg::axi_b_t        b_beat;
  logic                        b_load;
  logic                        b_done;
  logic                        rd_en;
  logic [`AXI_SRAM_IDX_W-1:0]  rd_idx;
  logic [`AXI_SRAM_DATA_W-1:0] rd_data;
  logic [`AXI_SRAM_ID_W-1:0]   r_id;
  axi_sram_pkg::axi_resp_e     r_resp;
  logic                        r_load;
  logic                        r_done;

  axi_sram_wr_req u_wr_req (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_aw      (i_aw),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_w       (i_w),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .o_sram_wr (sram_wr),
    .o_sram_we (sram_we),
    .o_b       (b_beat),
    .o_b_load  (b_load),
    .i_b_done  (b_done)
  );

  axi_sram_rd_req u_rd_req (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_ar      (i_ar),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .o_rd_en   (rd_en),
    .o_rd_idx  (rd_idx),
    .o_r_id    (r_id),
    .o_r_resp  (r_resp),
    .o_r_load  (r_load),
    .i_r_done  (r_done)
  );

  axi_sram_array u_array (
    .i_aclk    (i_aclk),
    .i_sram_wr (sram_wr),
    .i_we      (sram_we),
    .i_rd_en   (rd_en),
    .i_rd_idx  (rd_idx),
    .o_rd_data (rd_data)
  );

  axi_sram_resp u_resp (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_b       (b_beat),
    .i_b_load  (b_load),
    .o_b       (o_b),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_b_done  (b_done),
    .i_r_id    (r_id),
    .i_r_resp  (r_resp),
    .i_r_load  (r_load),
    .i_rd_data (rd_data),
    .o_r       (o_r),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_r_done  (r_done)
  );

endmodule

`default_nettype wire

// File: verification/axi_sram_checker.sv
// Scoreboard for the AXI SRAM slave that mirrors the SRAM and checks every B and R beat
`include "axi_sram_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module axi_sram_checker (
  input  wire                    i_aclk,
  input  wire                    i_rst_n,
  input  axi_sram_pkg::axi_aw_t  i_aw,
  input  wire                    i_awvalid,
  input  wire                    i_awready,
  input  axi_sram_pkg::axi_w_t   i_w,
  input  wire                    i_wvalid,
  input  wire                    i_wready,
  input  axi_sram_pkg::axi_b_t   i_b,
  input  wire                    i_bvalid,
  input  wire                    i_bready,
  input  axi_sram_pkg::axi_ar_t  i_ar,
  input  wire                    i_arvalid,
  input  wire                    i_arready,
  input  axi_sram_pkg::axi_r_t   i_r,
  input  wire                    i_rvalid,
  input  wire                    i_rready,
  output int                     o_tests,
  output int                     o_fails
);

  logic [`AXI_SRAM_DATA_W-1:0] model [`AXI_SRAM_DEPTH];
  axi_sram_pkg::axi_aw_t       aw_q;
  axi_sram_pkg::axi_b_t        b_exp;
  axi_sram_pkg::axi_r_t        r_exp;
  logic                        aw_wait = 1'b0;
  logic                        b_pend = 1'b0;
  logic                        r_pend = 1'b0;
  logic                        w_ok;
  int                          b_errs = 0;
  int                          r_errs = 0;
  int                          b_stalls = 0;
  int                          r_stalls = 0;
  int                          test_cnt = 0;
  int                          fail_cnt = 0;

  assign o_tests = test_cnt;
  // Errors seen outside any finished test count as one more failure
  assign o_fails = fail_cnt + (((b_errs != 0) || (r_errs != 0)) ? 1 : 0);

  // Memory starts out all zero
  initial begin
    for (int i = 0; i < `AXI_SRAM_DEPTH; i++) begin
      model[i] = '0;
    end
  end

  // ----------------------------------------
  // Reference rules
  // ----------------------------------------
  function automatic logic single_in_range(input logic [`AXI_SRAM_ADDR_W-1:0] addr,
                                           input logic [7:0] len);
    return (len == 8'd0) && (addr < `AXI_SRAM_DEPTH * `AXI_SRAM_STRB_W);
  endfunction

  function automatic int word_of(input logic [`AXI_SRAM_ADDR_W-1:0] addr);
    return int'(addr / `AXI_SRAM_STRB_W);
  endfunction

  function automatic logic [`AXI_SRAM_DATA_W-1:0] merge_bytes(
      input logic [`AXI_SRAM_DATA_W-1:0] old_word,
      input logic [`AXI_SRAM_DATA_W-1:0] new_word,
      input logic [`AXI_SRAM_STRB_W-1:0] strb);
    logic [`AXI_SRAM_DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < `AXI_SRAM_STRB_W; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic compare_field(input string name, input logic [63:0] exp,
                               input logic [63:0] got, inout int errs);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
      errs++;
    end
  endtask

  task automatic finish_test(input string kind, input int id, input int errs,
                             input int stalls);
    test_cnt++;
    if (errs != 0) fail_cnt++;
    $display("Test %0d: %s id %0h, %0d stall cycles, %s", test_cnt, kind, id, stalls,
             (errs == 0) ? "ok" : "FAILED");
  endtask

  // ----------------------------------------
  // Port monitor
  // ----------------------------------------
  always @(posedge i_aclk) begin
    if (i_rst_n) begin
      // One transaction in flight per direction
      compare_field("o_awready", 64'(!(aw_wait || b_pend)), 64'(i_awready), b_errs);
      compare_field("o_wready", 64'(aw_wait), 64'(i_wready), b_errs);
      compare_field("o_arready", 64'(!r_pend), 64'(i_arready), r_errs);

      // B beat compared on every cycle it is shown, stalls included
      if (i_bvalid) begin
        if (!b_pend) begin
          $display("B beat at %0t with no write outstanding", $time);
          b_errs++;
        end else begin
          compare_field("o_b.id", 64'(b_exp.id), 64'(i_b.id), b_errs);
          compare_field("o_b.resp", 64'(b_exp.resp), 64'(i_b.resp), b_errs);
        end
        if (i_bready) begin
          finish_test("write", int'(b_exp.id), b_errs, b_stalls);
          b_pend   = 1'b0;
          b_errs   = 0;
          b_stalls = 0;
        end else begin
          b_stalls++;
        end
      end

      if (i_rvalid) begin
        if (!r_pend) begin
          $display("R beat at %0t with no read outstanding", $time);
          r_errs++;
        end else begin
          compare_field("o_r.id", 64'(r_exp.id), 64'(i_r.id), r_errs);
          compare_field("o_r.data", r_exp.data, i_r.data, r_errs);
          compare_field("o_r.resp", 64'(r_exp.resp), 64'(i_r.resp), r_errs);
          compare_field("o_r.last", 64'(r_exp.last), 64'(i_r.last), r_errs);
        end
        if (i_rready) begin
          finish_test("read", int'(r_exp.id), r_errs, r_stalls);
          r_pend   = 1'b0;
          r_errs   = 0;
          r_stalls = 0;
        end else begin
          r_stalls++;
        end
      end

      // Read sees memory as it was before a write on the same edge
      if (i_arvalid && i_arready) begin
        r_exp.id   = i_ar.id;
        r_exp.last = 1'b1;
        if (single_in_range(i_ar.addr, i_ar.len)) begin
          r_exp.data = model[word_of(i_ar.addr)];
          r_exp.resp = axi_sram_pkg::OKAY;
        end else begin
          r_exp.data = '0;
          r_exp.resp = axi_sram_pkg::SLVERR;
        end
        r_pend = 1'b1;
      end

      if (i_awvalid && i_awready) begin
        aw_q    = i_aw;
        aw_wait = 1'b1;
      end

      if (i_wvalid && i_wready) begin
        w_ok       = single_in_range(aw_q.addr, aw_q.len) && i_w.last;
        b_exp.id   = aw_q.id;
        b_exp.resp = w_ok ? axi_sram_pkg::OKAY : axi_sram_pkg::SLVERR;
        b_pend     = 1'b1;
        aw_wait    = 1'b0;
        if (w_ok) begin
          model[word_of(aw_q.addr)] = merge_bytes(model[word_of(aw_q.addr)], i_w.data, i_w.strb);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/axi_sram_tb.sv
// Testbench for the AXI SRAM slave with a table of writes and reads and random B and R stalls
`include "axi_sram_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module axi_sram_tb;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_ROWS   = 15;

  typedef enum logic {
    OP_RD = 1'b0,
    OP_WR = 1'b1
  } op_e;

  typedef struct packed {
    op_e                         op;
    logic [`AXI_SRAM_ID_W-1:0]   id;
    logic [`AXI_SRAM_ADDR_W-1:0] addr;
    logic [7:0]                  len;
    logic [`AXI_SRAM_DATA_W-1:0] data;
    logic [`AXI_SRAM_STRB_W-1:0] strb;
  } row_t;

  logic                  aclk;
  logic                  rst_n;
  axi_sram_pkg::axi_aw_t aw;
  logic                  awvalid;
  logic                  awready;
  axi_sram_pkg::axi_w_t  w;
  logic                  wvalid;
  logic                  wready;
  axi_sram_pkg::axi_b_t  b;
  logic                  bvalid;
  logic                  bready;
  axi_sram_pkg::axi_ar_t ar;
  logic                  arvalid;
  logic                  arready;
  axi_sram_pkg::axi_r_t  r;
  logic                  rvalid;
  logic                  rready;
  int                    tests;
  int                    fails;
  int                    seed = 32;
  row_t                  rows [NUM_ROWS];

  axi_sram_top u_axi_sram_top (
    .i_aclk (aclk), .i_rst_n (rst_n),
    .i_aw (aw), .i_awvalid (awvalid), .o_awready (awready),
    .i_w (w), .i_wvalid (wvalid), .o_wready (wready),
    .o_b (b), .o_bvalid (bvalid), .i_bready (bready),
    .i_ar (ar), .i_arvalid (arvalid), .o_arready (arready),
    .o_r (r), .o_rvalid (rvalid), .i_rready (rready)
  );

  axi_sram_checker u_checker (
    .i_aclk (aclk), .i_rst_n (rst_n),
    .i_aw (aw), .i_awvalid (awvalid), .i_awready (awready),
    .i_w (w), .i_wvalid (wvalid), .i_wready (wready),
    .i_b (b), .i_bvalid (bvalid), .i_bready (bready),
    .i_ar (ar), .i_arvalid (arvalid), .i_arready (arready),
    .i_r (r), .i_rvalid (rvalid), .i_rready (rready),
    .o_tests (tests), .o_fails (fails)
  );

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  task automatic load_rows();
    rows[0]  = '{OP_RD, 4'h1, 32'h0000_0040, 8'd0, 64'h0, 8'h00};
    rows[1]  = '{OP_WR, 4'h2, 32'h0000_0008, 8'd0, 64'h1122_3344_5566_7788, 8'hff};
    rows[2]  = '{OP_RD, 4'h3, 32'h0000_0008, 8'd0, 64'h0, 8'h00};
    rows[3]  = '{OP_WR, 4'h4, 32'h0000_0008, 8'd0, 64'haaaa_aaaa_aaaa_aaaa, 8'h0f};
    rows[4]  = '{OP_RD, 4'h5, 32'h0000_0008, 8'd0, 64'h0, 8'h00};
    // Beyond the SRAM, aliases word 0 if the range check were missing
    rows[5]  = '{OP_WR, 4'h6, 32'h0000_1000, 8'd0, 64'hdead_beef_dead_beef, 8'hff};
    rows[6]  = '{OP_RD, 4'h7, 32'h0000_1000, 8'd0, 64'h0, 8'h00};
    rows[7]  = '{OP_RD, 4'h8, 32'h0000_0000, 8'd0, 64'h0, 8'h00};
    rows[8]  = '{OP_WR, 4'h9, 32'h0000_0010, 8'd3, 64'hcafe_f00d_cafe_f00d, 8'hff};
    rows[9]  = '{OP_RD, 4'ha, 32'h0000_0010, 8'd0, 64'h0, 8'h00};
    rows[10] = '{OP_RD, 4'hb, 32'h0000_0010, 8'd1, 64'h0, 8'h00};
    rows[11] = '{OP_WR, 4'hc, 32'h0000_07f8, 8'd0, 64'h0123_4567_89ab_cdef, 8'hff};
    rows[12] = '{OP_RD, 4'hd, 32'h0000_07f8, 8'd0, 64'h0, 8'h00};
    rows[13] = '{OP_WR, 4'he, 32'h0000_0018, 8'd0, 64'hffee_ddcc_bbaa_9988, 8'h81};
    rows[14] = '{OP_RD, 4'hf, 32'h0000_0018, 8'd0, 64'h0, 8'h00};
  endtask

  // Readies are looked at on the falling edge, where they are stable
  task automatic write_word(input row_t row);
    logic fire;
    aw      = '{id: row.id, addr: row.addr, len: row.len, size: 2'd3};
    w       = '{data: row.data, strb: row.strb, last: (row.len == 8'd0)};
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!awready) @(negedge aclk);
    @(negedge aclk);
    awvalid = 1'b0;
    while (!wready) @(negedge aclk);
    @(negedge aclk);
    wvalid = 1'b0;
    do begin
      bready = ($random(seed) & 3) != 0;
      fire   = bready & bvalid;
      @(negedge aclk);
    end while (!fire);
    bready = 1'b0;
  endtask

  task automatic read_word(input row_t row);
    logic fire;
    ar      = '{id: row.id, addr: row.addr, len: row.len, size: 2'd3};
    arvalid = 1'b1;
    while (!arready) @(negedge aclk);
    @(negedge aclk);
    arvalid = 1'b0;
    do begin
      rready = ($random(seed) & 3) != 0;
      fire   = rready & rvalid;
      @(negedge aclk);
    end while (!fire);
    rready = 1'b0;
  endtask

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    rst_n   = 1'b0;
    aw      = '0;
    awvalid = 1'b0;
    w       = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    ar      = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    load_rows();
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    rst_n = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (rows[i].op == OP_WR) begin
        write_word(rows[i]);
      end else begin
        read_word(rows[i]);
      end
    end
    repeat (2) @(negedge aclk);
    $display("Summary: %0d of %0d tests run, %0d failed", tests, NUM_ROWS, fails);
    if (fails == 0 && tests == NUM_ROWS) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog allows 40 cycles per row plus reset
  initial begin
    repeat (NUM_ROWS * 40 + 3) @(posedge aclk);
    $display("Watchdog expired: a handshake never completed");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+src
src/axi_sram_pkg.sv
src/axi_sram_wr_req.sv
src/axi_sram_rd_req.sv
src/axi_sram_array.sv
src/axi_sram_resp.sv
src/axi_sram_top.sv
verification/axi_sram_checker.sv
verification/axi_sram_tb.sv

// File: Makefile
SIM     := verilator
FLAGS   := --binary --timing --assert -j 0
TOP     := axi_sram_tb
FLIST   := flist.f
OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(filter %.sv,$(shell cat $(FLIST))) $(wildcard src/*.svh)
PASS    := All tests passed!

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)
